//--- mips_system.f
design/mips_pkg.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_decoder.sv
design/mips_cpu.sv
design/avalon_ram.sv
design/mips_system.sv
tb/mips_system_chk.sv
tb/mips_system_tb.sv

//--- Bender.yml
package:
  name: mips_system

sources:
  - design/mips_pkg.sv
  - design/mips_regfile.sv
  - design/mips_alu.sv
  - design/mips_decoder.sv
  - design/mips_cpu.sv
  - design/avalon_ram.sv
  - design/mips_system.sv
  - target: test
    files:
      - tb/mips_system_chk.sv
      - tb/mips_system_tb.sv

//--- tb/mips_system_tb.sv
`timescale 1ns/1ps

module mips_system_tb
    import mips_pkg::*;
();

    logic                      clk;
    logic                      reset;
    logic                      load_en;
    logic [LOAD_ADDR_BITS-1:0] load_addr;
    word_t                     load_data;
    logic                      active;
    word_t                     register_v0;

    word_t prog [$];              // program words, placed from byte address 4 on.
    word_t image [MEM_WORDS];
    word_t ref_mem [MEM_WORDS];
    word_t lfsr_state = 32'd34;
    word_t expected_v0;
    int    ref_steps;
    int    run_count = 0;
    int    runs_checked = 0;
    int    error_count = 0;
    int    cycle_count = 0;
    int    cycle_budget = 0;

    mips_system mips_system_i (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .active(active), .register_v0(register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t rtype_word(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt,
                                         reg_idx_t rd, logic [4:0] sh);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic word_t lfsr_next(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(int n);
        word_t r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};    // one step per bit.
        end
        return r;
    endfunction

    function automatic word_t fill_word(int idx);
        return 32'hC3A5_0000 ^ (word_t'(idx) * 32'h0104_0811);
    endfunction

    function automatic void emit(word_t w);
        prog.push_back(w);
    endfunction

    // jr $0 with a nop in its delay slot ends every program.
    function automatic void emit_halt();
        emit(rtype_word(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'h0000_0000);
    endfunction

    // instruction set interpreter that works on ref_mem and returns the final $v0.
    function automatic word_t reference_v0();
        word_t      regs [32];
        word_t      pc;
        word_t      target;
        word_t      ir;
        word_t      rs_v;
        word_t      rt_v;
        word_t      simm;
        word_t      zimm;
        word_t      tgt;
        word_t      ea;
        reg_idx_t   rd;
        reg_idx_t   rt;
        logic [5:0] op;
        logic       delay;
        logic       taken;
        logic       halting;
        foreach (regs[i]) regs[i] = '0;
        pc = 32'd4;
        target = '0;
        delay = 1'b0;
        halting = 1'b0;
        ref_steps = 0;
        while (!halting && ref_steps < 4000) begin
            ir   = ref_mem[pc[7:2]];
            op   = ir[31:26];
            rd   = ir[15:11];
            rt   = ir[20:16];
            rs_v = regs[ir[25:21]];
            rt_v = regs[rt];
            simm = {{16{ir[15]}}, ir[15:0]};
            zimm = {16'h0000, ir[15:0]};
            ea   = rs_v + simm;
            tgt  = pc + 32'd4 + {simm[29:0], 2'b00};
            taken = 1'b0;
            if (op == OP_SPECIAL) begin
                case (ir[5:0])
                    FN_ADDU: regs[rd] = rs_v + rt_v;
                    FN_SUBU: regs[rd] = rs_v - rt_v;
                    FN_AND:  regs[rd] = rs_v & rt_v;
                    FN_OR:   regs[rd] = rs_v | rt_v;
                    FN_XOR:  regs[rd] = rs_v ^ rt_v;
                    FN_SLT:  regs[rd] = {31'b0, $signed(rs_v) < $signed(rt_v)};
                    FN_SLTU: regs[rd] = {31'b0, rs_v < rt_v};
                    FN_SLL:  regs[rd] = rt_v << ir[10:6];
                    FN_SRL:  regs[rd] = rt_v >> ir[10:6];
                    FN_SRA:  regs[rd] = $signed(rt_v) >>> ir[10:6];
                    FN_JR: begin
                        taken = 1'b1;
                        tgt   = rs_v;
                    end
                    default: ;
                endcase
            end else begin
                case (op)
                    OP_ADDIU: regs[rt] = rs_v + simm;
                    OP_SLTI:  regs[rt] = {31'b0, $signed(rs_v) < $signed(simm)};
                    OP_SLTIU: regs[rt] = {31'b0, rs_v < simm};    // sign extended, unsigned compare.
                    OP_ANDI:  regs[rt] = rs_v & zimm;
                    OP_ORI:   regs[rt] = rs_v | zimm;
                    OP_XORI:  regs[rt] = rs_v ^ zimm;
                    OP_LUI:   regs[rt] = {ir[15:0], 16'h0000};
                    OP_LW:    regs[rt] = ref_mem[ea[7:2]];
                    OP_SW:    ref_mem[ea[7:2]] = rt_v;
                    OP_BEQ:   taken = (rs_v == rt_v);
                    OP_BNE:   taken = (rs_v != rt_v);
                    default: ;
                endcase
            end
            regs[0] = '0;
            // a pending target is taken after the delay slot has executed.
            halting = delay && (target == '0);
            pc = delay ? target : pc + 32'd4;
            delay = taken;
            if (taken) begin
                target = tgt;
            end
            ref_steps++;
        end
        return regs[2];
    endfunction

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s: got %08h, expected %08h", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic build_alu_program();
        int          sel;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
        logic [4:0]  sh;
        for (int i = 0; i < 24; i++) begin
            sel = int'(rand_bits(5) % 17);
            rd  = reg_idx_t'(rand_bits(3));    // registers 0 to 7 keep operands dependent.
            rs  = reg_idx_t'(rand_bits(3));
            rt  = reg_idx_t'(rand_bits(3));
            imm = 16'(rand_bits(16));
            sh  = 5'(rand_bits(5));
            case (sel)
                0:  emit(rtype_word(FN_ADDU, rs, rt, rd, 5'd0));
                1:  emit(rtype_word(FN_SUBU, rs, rt, rd, 5'd0));
                2:  emit(rtype_word(FN_AND, rs, rt, rd, 5'd0));
                3:  emit(rtype_word(FN_OR, rs, rt, rd, 5'd0));
                4:  emit(rtype_word(FN_XOR, rs, rt, rd, 5'd0));
                5:  emit(rtype_word(FN_SLT, rs, rt, rd, 5'd0));
                6:  emit(rtype_word(FN_SLTU, rs, rt, rd, 5'd0));
                7:  emit(rtype_word(FN_SLL, 5'd0, rt, rd, sh));
                8:  emit(rtype_word(FN_SRL, 5'd0, rt, rd, sh));
                9:  emit(rtype_word(FN_SRA, 5'd0, rt, rd, sh));
                10: emit(itype_word(OP_ADDIU, rs, rd, imm));
                11: emit(itype_word(OP_SLTI, rs, rd, imm));
                12: emit(itype_word(OP_SLTIU, rs, rd, imm));
                13: emit(itype_word(OP_ANDI, rs, rd, imm));
                14: emit(itype_word(OP_ORI, rs, rd, imm));
                15: emit(itype_word(OP_XORI, rs, rd, imm));
                default: emit(itype_word(OP_LUI, 5'd0, rd, imm));
            endcase
        end
        // fold the other registers into $v0 so that every result is seen.
        for (int r = 1; r < 8; r++) begin
            if (r != 2) begin
                emit(rtype_word(FN_XOR, 5'd2, reg_idx_t'(r), 5'd2, 5'd0));
            end
        end
        emit_halt();
    endtask

    task automatic build_memory_program();
        emit(itype_word(OP_ADDIU, 5'd0, 5'd8, 16'd160));    // base at word 40.
        for (int r = 3; r < 8; r++) begin
            emit(itype_word(OP_LUI, 5'd0, reg_idx_t'(r), 16'(rand_bits(16))));
            emit(itype_word(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), 16'(rand_bits(16))));
        end
        for (int r = 3; r < 8; r++) begin
            emit(itype_word(OP_SW, 5'd8, reg_idx_t'(r), 16'((r - 3) * 4)));
        end
        emit(itype_word(OP_SW, 5'd8, 5'd6, 16'd8));          // overwrites the word of $5.
        emit(itype_word(OP_ADDIU, 5'd0, 5'd9, 16'd200));
        emit(itype_word(OP_SW, 5'd9, 5'd4, 16'hFFFC));        // a negative offset reaches word 49.
        emit(itype_word(OP_LW, 5'd8, 5'd2, 16'd8));
        emit(itype_word(OP_LW, 5'd8, 5'd10, 16'd0));
        emit(rtype_word(FN_XOR, 5'd2, 5'd10, 5'd2, 5'd0));
        emit(itype_word(OP_LW, 5'd8, 5'd11, 16'd16));
        emit(rtype_word(FN_XOR, 5'd2, 5'd11, 5'd2, 5'd0));
        emit(itype_word(OP_LW, 5'd8, 5'd12, 16'd36));
        emit(rtype_word(FN_ADDU, 5'd2, 5'd12, 5'd2, 5'd0));
        emit(itype_word(OP_LW, 5'd8, 5'd13, 16'd80));         // untouched fill word 60.
        emit(rtype_word(FN_XOR, 5'd2, 5'd13, 5'd2, 5'd0));
        emit_halt();
    endtask

    task automatic build_branch_program();
        emit(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd1));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd3, 16'd7));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd4, 16'd7));
        emit(itype_word(OP_BEQ, 5'd3, 5'd4, 16'd2));          // taken.
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd16));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd256));
        emit(itype_word(OP_BNE, 5'd3, 5'd4, 16'd2));          // not taken.
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd32));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd64));
        emit(itype_word(OP_BEQ, 5'd3, 5'd0, 16'd2));          // not taken.
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd512));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd1024));
        emit(itype_word(OP_BNE, 5'd3, 5'd0, 16'd2));          // taken.
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd2048));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd4096));
        // a backward loop with its counter decremented in the delay slot.
        emit(itype_word(OP_ADDIU, 5'd0, 5'd5, 16'd3));
        emit(rtype_word(FN_ADDU, 5'd2, 5'd2, 5'd2, 5'd0));
        emit(itype_word(OP_BNE, 5'd5, 5'd0, 16'hFFFE));
        emit(itype_word(OP_ADDIU, 5'd5, 5'd5, 16'hFFFF));
        emit(rtype_word(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd3));        // runs before the halt.
    endtask

    task automatic build_zero_program();
        emit(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'hFFFF));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
        emit(itype_word(OP_LUI, 5'd0, 5'd0, 16'h1234));
        emit(rtype_word(FN_ADDU, 5'd2, 5'd2, 5'd0, 5'd0));
        emit(itype_word(OP_LW, 5'd0, 5'd0, 16'd240));
        emit(rtype_word(FN_ADDU, 5'd0, 5'd0, 5'd2, 5'd0));    // copies $0 into $v0.
        emit_halt();
    endtask

    // loads the image through the loader port, runs it and waits for the compare.
    task automatic run_program(string name);
        foreach (image[i]) image[i] = fill_word(i);
        foreach (prog[i]) image[i + 1] = prog[i];
        ref_mem = image;
        expected_v0 = reference_v0();
        cycle_budget += ref_steps * 20 + MEM_WORDS + 16;
        $display("running %s, %0d instructions", name, ref_steps);
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            load_en   <= 1'b1;
            load_addr <= LOAD_ADDR_BITS'(i * 4);
            load_data <= image[i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        run_count++;
        repeat (2) @(negedge clk);
        check_flag("active", active, 1'b1);
        wait (runs_checked == run_count);
        prog.delete();
    endtask

    always begin
        @(negedge active);
        if (!reset) begin
            @(negedge clk);
            check_word("register_v0", register_v0, expected_v0);
            // a halted CPU stays halted until the next reset.
            repeat (4) @(negedge clk);
            check_flag("active", active, 1'b0);
            runs_checked++;
        end
    end

    always @(mips_system_i.mips_cpu_i.chk_i.failures) begin
        if (mips_system_i.mips_cpu_i.chk_i.failures != 0) begin
            $display("a bus protocol assertion on the CPU master port failed");
            $display("Done: errors found");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_budget) begin
            $display("watchdog expired after %0d cycles, a program did not halt", cycle_count);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        emit(itype_word(OP_ADDIU, 5'd0, 5'd3, 16'd5));
        emit(rtype_word(FN_SLL, 5'd0, 5'd3, 5'd3, 5'd2));
        emit(itype_word(OP_SLTI, 5'd3, 5'd2, 16'd10));       // 20 < 10 leaves $v0 at zero.
        emit_halt();
        run_program("slti program");
        for (int t = 0; t < 4; t++) begin
            build_alu_program();
            run_program("random alu program");
        end
        for (int t = 0; t < 2; t++) begin
            build_memory_program();
            run_program("memory round trip");
        end
        build_branch_program();
        run_program("branches and delay slots");
        build_zero_program();
        run_program("register zero");
        if (error_count == 0 && mips_system_i.mips_cpu_i.chk_i.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb/mips_system_chk.sv
`timescale 1ns/1ps

module mips_system_chk
    import mips_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input word_t address,
    input logic  read,
    input logic  write,
    input logic  waitrequest,
    input word_t writedata
);

    int failures = 0;    // number of failed assertions so far.

    a_one_command: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write are high together");
            failures++;
        end

    // a stalled transfer must keep every master output unchanged.
    a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) &&
        $stable(write) && $stable(writedata))
        else begin
            $error("master outputs changed while waitrequest was high");
            failures++;
        end

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (address[1:0] == 2'b00))
        else begin
            $error("access address is not word aligned");
            failures++;
        end

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> !read && !write)
        else begin
            $error("bus command in the cycle after reset");
            failures++;
        end

endmodule

bind mips_cpu mips_system_chk chk_i (.*);

//--- design/mips_system.sv
`timescale 1ns/1ps

module mips_system
    import mips_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load_en,
    input  logic [LOAD_ADDR_BITS-1:0] load_addr,
    input  word_t                     load_data,
    output logic                      active,
    output word_t                     register_v0
);

    // Avalon bus between the CPU and the RAM.
    word_t      address;
    logic       read;
    logic       write;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    mips_cpu mips_cpu_i (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalon_ram avalon_ram_i (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .waitrequest(waitrequest), .writedata(writedata), .byteenable(byteenable),
        .readdata(readdata), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data)
    );

endmodule

//--- design/avalon_ram.sv
`timescale 1ns/1ps

module avalon_ram
    import mips_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  word_t                     address,
    input  logic                      read,
    input  logic                      write,
    output logic                      waitrequest,
    input  word_t                     writedata,
    input  logic [3:0]                byteenable,
    output word_t                     readdata,
    input  logic                      load_en,
    input  logic [LOAD_ADDR_BITS-1:0] load_addr,
    input  word_t                     load_data
);

    word_t                     mem [MEM_WORDS];
    logic [MEM_INDEX_BITS-1:0] bus_idx;
    logic [MEM_INDEX_BITS-1:0] load_idx;
    logic [WAIT_CNT_BITS-1:0]  wait_cnt;
    logic                      done;

    // byte addresses, the two low bits select a byte within the word.
    assign bus_idx  = address[MEM_INDEX_BITS+1:2];
    assign load_idx = load_addr[MEM_INDEX_BITS+1:2];

    // an access completes once it has been held for the fixed wait cycles.
    assign done        = (read || write) && (wait_cnt == WAIT_CNT_BITS'(RAM_WAIT_CYCLES));
    assign waitrequest = !done;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (done) begin
            wait_cnt <= '0;
        end else if (read || write) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;    // the testbench loads programs here.
        end else if (write && done) begin
            for (int i = 0; i < 4; i++) begin
                if (byteenable[i]) begin
                    mem[bus_idx][8*i +: 8] <= writedata[8*i +: 8];
                end
            end
        end
    end

    // read data is captured during the wait cycles and is valid when done.
    always_ff @(posedge clk) begin
        if (read) begin
            readdata <= mem[bus_idx];
        end
    end

endmodule

//--- design/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       read,
    output logic       write,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALTED
    } state_t;

    state_t state;
    word_t  pc;
    word_t  ir;
    word_t  alu_q;             // address for lw and sw, or the result to write back.
    word_t  mem_q;
    word_t  pending_target;
    logic   delay_pending;     // set while the delay-slot instruction runs.
    logic   halt_q;

    alu_op_t alu_op;
    logic    use_imm, imm_signed, reg_write, dest_rt;
    logic    mem_read, mem_write, is_branch, branch_ne, is_jr;

    word_t    rs_data, rt_data, imm_ext, alu_b, alu_result;
    word_t    branch_target, next_pc, rf_wr_data;
    logic     alu_zero, branch_taken, rf_wr_en;
    reg_idx_t wr_idx;

    mips_decoder decoder_i (
        .instr(ir), .alu_op(alu_op), .use_imm(use_imm), .imm_signed(imm_signed),
        .reg_write(reg_write), .dest_rt(dest_rt), .mem_read(mem_read),
        .mem_write(mem_write), .is_branch(is_branch), .branch_ne(branch_ne),
        .is_jr(is_jr)
    );

    mips_regfile regfile_i (
        .clk(clk), .reset(reset), .rs_idx(ir[25:21]), .rt_idx(ir[20:16]),
        .rs_data(rs_data), .rt_data(rt_data), .wr_en(rf_wr_en), .wr_idx(wr_idx),
        .wr_data(rf_wr_data), .v0(register_v0)
    );

    mips_alu alu_i (
        .op(alu_op), .a(rs_data), .b(alu_b), .shamt(ir[10:6]),
        .result(alu_result), .zero(alu_zero)
    );

    assign imm_ext = imm_signed ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
    assign alu_b   = use_imm ? imm_ext : rt_data;

    // beq takes the branch on zero, bne on non-zero.
    assign branch_taken  = (is_branch && (alu_zero != branch_ne)) || is_jr;
    assign branch_target = is_jr ? rs_data : pc + 32'd4 + {imm_ext[29:0], 2'b00};
    assign next_pc       = delay_pending ? pending_target : pc + 32'd4;

    assign wr_idx     = dest_rt ? ir[20:16] : ir[15:11];
    assign rf_wr_en   = (state == ST_WRITEBACK) && reg_write;
    assign rf_wr_data = mem_read ? mem_q : alu_q;

    // the bus outputs depend only on registers, so they hold during waitrequest.
    assign read       = (state == ST_FETCH) || ((state == ST_MEMORY) && mem_read);
    assign write      = (state == ST_MEMORY) && mem_write;
    assign address    = (state == ST_FETCH) ? pc : alu_q;
    assign writedata  = rt_data;
    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            pc             <= RESET_VECTOR;
            ir             <= '0;
            active         <= 1'b0;
            delay_pending  <= 1'b0;
            pending_target <= '0;
            halt_q         <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    active <= 1'b1;
                    state  <= ST_FETCH;
                end
                ST_FETCH: begin
                    if (!waitrequest) begin
                        ir    <= readdata;
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    pc            <= next_pc;
                    halt_q        <= delay_pending && (pending_target == '0);
                    delay_pending <= branch_taken;
                    if (branch_taken) begin
                        pending_target <= branch_target;
                    end
                    state <= (mem_read || mem_write) ? ST_MEMORY : ST_WRITEBACK;
                end
                ST_MEMORY: begin
                    if (!waitrequest) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    // the delay slot has retired, so a jump to zero may stop here.
                    if (halt_q) begin
                        active <= 1'b0;
                        state  <= ST_HALTED;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_HALTED: state <= ST_HALTED;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXECUTE) begin
            alu_q <= alu_result;
        end
        if (state == ST_MEMORY && !waitrequest) begin
            mem_q <= readdata;    // only meaningful for lw.
        end
    end

endmodule

//--- design/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder
    import mips_pkg::*;
(
    input  word_t   instr,
    output alu_op_t alu_op,
    output logic    use_imm,
    output logic    imm_signed,
    output logic    reg_write,
    output logic    dest_rt,
    output logic    mem_read,
    output logic    mem_write,
    output logic    is_branch,
    output logic    branch_ne,
    output logic    is_jr
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // defaults describe a no-op, anything not matched below stays one.
        alu_op     = ALU_ADD;
        use_imm    = 1'b0;
        imm_signed = 1'b1;
        reg_write  = 1'b0;
        dest_rt    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        is_branch  = 1'b0;
        branch_ne  = 1'b0;
        is_jr      = 1'b0;

        if (opcode == OP_SPECIAL) begin
            reg_write = 1'b1;    // cleared again for jr and unknown functs.
            case (funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                FN_SLL:  alu_op = ALU_SLL;
                FN_SRL:  alu_op = ALU_SRL;
                FN_SRA:  alu_op = ALU_SRA;
                FN_JR: begin
                    reg_write = 1'b0;
                    is_jr     = 1'b1;
                end
                default: reg_write = 1'b0;
            endcase
        end else begin
            // every I-type instruction takes the immediate, writes rt, or both.
            use_imm = 1'b1;
            dest_rt = 1'b1;
            case (opcode)
                OP_ADDIU: begin alu_op = ALU_ADD;  reg_write = 1'b1; end
                OP_SLTI:  begin alu_op = ALU_SLT;  reg_write = 1'b1; end
                OP_SLTIU: begin alu_op = ALU_SLTU; reg_write = 1'b1; end
                OP_ANDI:  begin alu_op = ALU_AND;  reg_write = 1'b1; imm_signed = 1'b0; end
                OP_ORI:   begin alu_op = ALU_OR;   reg_write = 1'b1; imm_signed = 1'b0; end
                OP_XORI:  begin alu_op = ALU_XOR;  reg_write = 1'b1; imm_signed = 1'b0; end
                OP_LUI:   begin alu_op = ALU_LUI;  reg_write = 1'b1; end
                OP_LW:    begin mem_read = 1'b1;   reg_write = 1'b1; end
                OP_SW:    mem_write = 1'b1;
                OP_BEQ, OP_BNE: begin
                    // compare rs with rt, the immediate is only the offset.
                    alu_op    = ALU_SUB;
                    use_imm   = 1'b0;
                    is_branch = 1'b1;
                    branch_ne = (opcode == OP_BNE);
                end
                default: begin
                    use_imm = 1'b0;
                    dest_rt = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- design/mips_alu.sv
`timescale 1ns/1ps

module mips_alu
    import mips_pkg::*;
(
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       zero
);

    logic lt_signed;
    logic lt_unsigned;

    // both comparisons are always formed, the op selects one of them.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;    // also used by beq and bne.
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            ALU_SLT: begin
                result = {31'b0, lt_signed};
            end
            ALU_SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            // shifts operate on the rt operand, as MIPS defines them.
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(b) >>> shamt);
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // a branch compares by subtracting, so equal operands give zero.
    assign zero = (result == '0);

endmodule

//--- design/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    v0
);

    // register 0 has no storage, it always reads as zero.
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    // the testbench reads the result of a program from $v0.
    assign v0 = regs[2];

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

    // basic data types shared by the CPU, the RAM and the top level.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // operations the ALU can perform.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // the first instruction is fetched from byte address 4.
    localparam word_t RESET_VECTOR = 32'h0000_0004;

    // memory geometry.
    localparam int MEM_WORDS       = 64;
    localparam int MEM_INDEX_BITS  = $clog2(MEM_WORDS);
    localparam int LOAD_ADDR_BITS  = 8;    // byte address of the loader port.
    localparam int RAM_WAIT_CYCLES = 1;    // must be at least one, readdata is registered.
    localparam int WAIT_CNT_BITS   = $clog2(RAM_WAIT_CYCLES + 1);

    // opcode field, bits 31 to 26.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_SLTIU   = 6'h0B;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // funct field of R-type instructions, bits 5 to 0.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

endpackage
